/* flist.f */
dcache_geom_pkg.sv
dcache_bus_pkg.sv
dcache_tags.sv
dcache_data.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache_mem.sv
tb_dcache.sv

/* tb_dcache.sv */
// Testbench top for the write-through data cache
// Clock, reset, request driver and snoop pulses
// Reference read function and data_valid comparison

module tb_dcache;
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;

    // Memory responds at +1, port side is driven at +2, outputs sampled at +3
    localparam int MEM_DLY    = 1;
    localparam int DRV_DLY    = 2;
    localparam int SAMPLE_DLY = 3;
    localparam int TIMEOUT    = 200;

    logic       clk;
    logic       rst;
    logic       new_request;
    byte_addr_t addr;
    logic       we;
    byte_en_t   be;
    word_t      data_in;
    logic       ready;
    logic       data_valid;
    word_t      data_out;
    logic       write_outstanding;
    logic       mem_request;
    word_addr_t mem_addr;
    logic       mem_rnw;
    byte_en_t   mem_wbe;
    word_t      mem_wdata;
    logic       mem_ack;
    logic       mem_rvalid;
    word_t      mem_rdata;
    logic       mem_inv;
    byte_addr_t mem_inv_addr;

    word_t       exp_q [$];
    int          issue_q [$];
    word_t       exp_word;
    int          cycle_cnt = 0;
    int          last_latency;
    string       test_name;
    byte_addr_t  a;
    byte_addr_t  b;

    dcache_top dcache_top_i (.*);

    tb_dcache_mem #(.DRIVE_DLY(MEM_DLY)) mem_i (
        .clk, .rst, .mem_request, .mem_addr, .mem_rnw, .mem_wbe, .mem_wdata,
        .mem_ack, .mem_rvalid, .mem_rdata
    );

    always #2 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    //////////////////////////////////////////////////////////////////////////
    // Reference and helpers

    // Write-through plus snoops keep memory as the expected read value
    function automatic word_t ref_read(input byte_addr_t ba);
        return mem_i.peek(ba[31:2]);
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #DRV_DLY;
            n++;
            if (n > TIMEOUT) stop_run("timeout waiting for the cache to become ready");
        end while (!ready);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #DRV_DLY;
            n++;
            if (n > TIMEOUT) stop_run("timeout waiting for outstanding requests to finish");
        end while (exp_q.size() != 0 || !ready || write_outstanding);
    endtask

    task automatic issue(input logic is_write, input byte_addr_t ba,
                         input byte_en_t bytes, input word_t d);
        wait_ready();
        new_request = 1'b1;
        we = is_write;
        addr = ba;
        be = bytes;
        data_in = d;
        if (!is_write) begin
            exp_q.push_back(ref_read(ba));
            issue_q.push_back(cycle_cnt);
        end
        @(posedge clk);
        #DRV_DLY;
        new_request = 1'b0;
        // Stage 1 holds the request now and flags only a write
        assert (write_outstanding === is_write)
            else stop_run($sformatf("[ERROR] %s: expected write_outstanding %b actual %b",
                                    test_name, is_write, write_outstanding));
    endtask

    task automatic pulse_snoop(input byte_addr_t ba);
        @(posedge clk);
        #DRV_DLY;
        mem_inv = 1'b1;
        mem_inv_addr = ba;
        @(posedge clk);
        #DRV_DLY;
        mem_inv = 1'b0;
    endtask

    // Each read response against the value taken when it was issued
    always begin
        @(posedge clk);
        #SAMPLE_DLY;
        if (!rst && data_valid) begin
            assert (exp_q.size() != 0)
                else stop_run("data_valid pulsed with no read outstanding");
            exp_word = exp_q.pop_front();
            last_latency = cycle_cnt - issue_q.pop_front();
            assert (data_out === exp_word)
                else stop_run($sformatf("[ERROR] %s: expected %h actual %h",
                                        test_name, exp_word, data_out));
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        void'($urandom(4));
        clk = 1'b0;
        rst = 1'b1;
        new_request = 1'b0;
        addr = '0;
        we = 1'b0;
        be = '0;
        data_in = '0;
        mem_inv = 1'b0;
        mem_inv_addr = '0;
        repeat (3) @(posedge clk);
        #DRV_DLY;
        rst = 1'b0;
        assert (!ready && !data_valid && !mem_request && !write_outstanding)
            else stop_run("cache outputs not idle after reset");

        test_name = "read_after_reset";
        a = $urandom() & ~32'h3;
        issue(1'b0, a, '0, '0);
        wait_idle();
        test_name = "repeat_read_hit";
        issue(1'b0, a, '0, '0);
        wait_idle();
        assert (last_latency == 1)
            else stop_run($sformatf("[ERROR] %s: expected latency 1 actual %0d",
                                    test_name, last_latency));

        test_name = "write_cached_line";
        issue(1'b1, a, 4'b0101, 32'hDEAD_BEEF);
        issue(1'b0, a, '0, '0);
        wait_idle();
        test_name = "write_uncached_line";
        b = a ^ 32'h0001_0000;
        issue(1'b1, b, 4'b1010, 32'h1234_5678);
        issue(1'b0, b, '0, '0);
        wait_idle();

        // Backdoor change is only visible once the snoop drops the line
        test_name = "snoop_invalidate";
        issue(1'b0, a, '0, '0);
        wait_idle();
        mem_i.poke(a[31:2], ~ref_read(a));
        pulse_snoop(a);
        issue(1'b0, a, '0, '0);
        wait_idle();

        test_name = "same_index_lines";
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 3; k++) begin
                issue(1'b0, 32'h0000_4040 + k * 32'h200, '0, '0);
            end
        end
        wait_idle();

        test_name = "random_mix";
        for (int n = 0; n < 300; n++) begin
            a = 32'h0000_8000 + 4 * $urandom_range(0, 383);
            issue($urandom_range(0, 1) == 1, a, byte_en_t'($urandom_range(1, 15)), $urandom());
        end
        wait_idle();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* tb_dcache_mem.sv */
// Memory model for the data cache testbench
// Request/ack with random delay, line fill bursts with random gaps
// Byte-merged writes into a sparse word store
// Backdoor read and write tasks for the testbench

module tb_dcache_mem #(
    parameter int DRIVE_DLY = 1
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       mem_request,
    input  dcache_bus_pkg::word_addr_t mem_addr,
    input  logic                       mem_rnw,
    input  dcache_bus_pkg::byte_en_t   mem_wbe,
    input  dcache_bus_pkg::word_t      mem_wdata,
    output logic                       mem_ack,
    output logic                       mem_rvalid,
    output dcache_bus_pkg::word_t      mem_rdata
);
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;

    // Only written words are stored, the rest come from the fill pattern
    word_t store [word_addr_t];

    //////////////////////////////////////////////////////////////////////////
    // Word store access

    // Every address bit changes the pattern
    function automatic word_t fill_word(input word_addr_t a);
        return {a, 2'b00} ^ {a[13:0], a[29:12]} ^ 32'h3C5A_96E1;
    endfunction

    function automatic word_t peek(input word_addr_t a);
        return store.exists(a) ? store[a] : fill_word(a);
    endfunction

    task automatic poke(input word_addr_t a, input word_t d);
        store[a] = d;
    endtask

    task automatic merge_write(input word_addr_t a, input byte_en_t b, input word_t d);
        word_t w;
        w = peek(a);
        for (int i = 0; i < $bits(byte_en_t); i++) begin
            if (b[i]) begin
                w[8*i +: 8] = d[8*i +: 8];
            end
        end
        store[a] = w;
    endtask

    //////////////////////////////////////////////////////////////////////////
    // Bus side

    task automatic serve_request();
        word_addr_t a;
        repeat ($urandom_range(0, 3)) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        a = mem_addr;
        mem_ack = 1'b1;
        if (!mem_rnw) begin
            merge_write(a, mem_wbe, mem_wdata);
        end else begin
            // Burst from word 0 of the line, gaps allowed between words
            for (int i = 0; i < LINE_WORDS; i++) begin
                @(posedge clk);
                #DRIVE_DLY;
                mem_ack = 1'b0;
                mem_rvalid = 1'b0;
                repeat ($urandom_range(0, 2)) begin
                    @(posedge clk);
                    #DRIVE_DLY;
                end
                mem_rvalid = 1'b1;
                mem_rdata = peek(word_addr_t'(a + word_addr_t'(i)));
            end
        end
    endtask

    initial begin
        mem_ack = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            mem_ack = 1'b0;
            mem_rvalid = 1'b0;
            if (!rst && mem_request) begin
                serve_request();
            end
        end
    end

endmodule

/* dcache_top.sv */
// Top level of the write-through data cache
// Control, tag bank and data bank instances
// Load/store port and memory bus pins

module dcache_top (
    input  logic                       clk,
    input  logic                       rst,
    // Load/store port
    input  logic                       new_request,
    input  dcache_bus_pkg::byte_addr_t addr,
    input  logic                       we,
    input  dcache_bus_pkg::byte_en_t   be,
    input  dcache_bus_pkg::word_t      data_in,
    output logic                       ready,
    output logic                       data_valid,
    output dcache_bus_pkg::word_t      data_out,
    output logic                       write_outstanding,
    // Memory side
    output logic                       mem_request,
    output dcache_bus_pkg::word_addr_t mem_addr,
    output logic                       mem_rnw,
    output dcache_bus_pkg::byte_en_t   mem_wbe,
    output dcache_bus_pkg::word_t      mem_wdata,
    input  logic                       mem_ack,
    input  logic                       mem_rvalid,
    input  dcache_bus_pkg::word_t      mem_rdata,
    input  logic                       mem_inv,
    input  dcache_bus_pkg::byte_addr_t mem_inv_addr
);
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;

    // Control to tag bank
    logic      lookup_en;
    line_t     lookup_line;
    tag_t      req_tag;
    logic      alloc_en;
    line_t     alloc_line;
    way_mask_t alloc_way;
    logic      hit;
    way_mask_t hit_way;
    logic      snoop_busy;
    logic      sweeping;

    // Control to data bank
    logic                 db_wen;
    logic [DB_ADDR_W-1:0] db_waddr;
    way_mask_t            db_way;
    byte_en_t             db_be;
    word_t                db_wdata;
    logic                 db_ren;
    logic [DB_ADDR_W-1:0] db_raddr;
    word_t                hit_word;

    dcache_ctrl ctrl_i (
        .clk, .rst,
        .new_request, .addr, .we, .be, .data_in,
        .ready, .data_valid, .data_out, .write_outstanding,
        .mem_request, .mem_addr, .mem_rnw, .mem_wbe, .mem_wdata,
        .mem_ack, .mem_rvalid, .mem_rdata,
        .lookup_en, .lookup_line, .req_tag,
        .alloc_en, .alloc_line, .alloc_way,
        .hit, .hit_way, .snoop_busy, .sweeping,
        .db_wen, .db_waddr, .db_way, .db_be, .db_wdata,
        .db_ren, .db_raddr, .hit_word
    );

    dcache_tags tags_i (
        .clk, .rst,
        .lookup_en, .lookup_line, .req_tag,
        .alloc_en, .alloc_line, .alloc_way,
        .mem_inv, .mem_inv_addr,
        .hit, .hit_way, .snoop_busy, .sweeping
    );

    dcache_data data_i (
        .clk,
        .db_wen, .db_waddr, .db_way, .db_be, .db_wdata,
        .db_ren, .db_raddr, .hit_way, .hit_word
    );

endmodule

/* dcache_ctrl.sv */
// Control of the data cache
// Stage 1 request register and completion logic
// Memory request handshake and fill word counter
// Tag allocation, data bank writes and replacement pointer

module dcache_ctrl (
    input  logic                                  clk,
    input  logic                                  rst,
    // Load/store port
    input  logic                                  new_request,
    input  dcache_bus_pkg::byte_addr_t            addr,
    input  logic                                  we,
    input  dcache_bus_pkg::byte_en_t              be,
    input  dcache_bus_pkg::word_t                 data_in,
    output logic                                  ready,
    output logic                                  data_valid,
    output dcache_bus_pkg::word_t                 data_out,
    output logic                                  write_outstanding,
    // Memory side
    output logic                                  mem_request,
    output dcache_bus_pkg::word_addr_t            mem_addr,
    output logic                                  mem_rnw,
    output dcache_bus_pkg::byte_en_t              mem_wbe,
    output dcache_bus_pkg::word_t                 mem_wdata,
    input  logic                                  mem_ack,
    input  logic                                  mem_rvalid,
    input  dcache_bus_pkg::word_t                 mem_rdata,
    // Tag bank
    output logic                                  lookup_en,
    output dcache_geom_pkg::line_t                lookup_line,
    output dcache_geom_pkg::tag_t                 req_tag,
    output logic                                  alloc_en,
    output dcache_geom_pkg::line_t                alloc_line,
    output dcache_geom_pkg::way_mask_t            alloc_way,
    input  logic                                  hit,
    input  dcache_geom_pkg::way_mask_t            hit_way,
    input  logic                                  snoop_busy,
    input  logic                                  sweeping,
    // Data bank
    output logic                                  db_wen,
    output logic [dcache_geom_pkg::DB_ADDR_W-1:0] db_waddr,
    output dcache_geom_pkg::way_mask_t            db_way,
    output dcache_bus_pkg::byte_en_t              db_be,
    output dcache_bus_pkg::word_t                 db_wdata,
    output logic                                  db_ren,
    output logic [dcache_geom_pkg::DB_ADDR_W-1:0] db_raddr,
    input  dcache_bus_pkg::word_t                 hit_word
);
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;

    logic       s1_valid;
    req_kind_t  s1_kind;
    word_addr_t s1_addr;
    byte_en_t   s1_be;
    word_t      s1_wdata;
    line_t      s1_line;
    word_sel_t  s1_word;
    logic       s1_done;

    logic      first_cycle;
    logic      request_sent;
    logic      alloc_pend;
    word_sel_t word_cnt;
    logic      fill_last;
    logic      fill_match;
    way_mask_t repl_way;

    ////////////////////////////////////////////////////////////////////////////
    // Request cycle

    // Tag and data banks are read while the request is registered
    assign lookup_en   = new_request;
    assign lookup_line = addr[2+WORD_SEL_W +: LINE_ADDR_W];
    assign db_ren      = new_request;
    assign db_raddr    = addr[2 +: DB_ADDR_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid    <= 1'b0;
            s1_kind     <= REQ_READ;
            first_cycle <= 1'b0;
        end else begin
            first_cycle <= new_request;
            if (new_request) begin
                s1_valid <= 1'b1;
                s1_kind  <= we ? REQ_WRITE : REQ_READ;
            end else if (s1_done) begin
                s1_valid <= 1'b0;
            end
        end
        if (new_request) begin
            s1_addr  <= addr[31:2];
            s1_be    <= be;
            s1_wdata <= data_in;
        end
    end

    assign s1_line = s1_addr[WORD_SEL_W +: LINE_ADDR_W];
    assign s1_word = s1_addr[WORD_SEL_W-1:0];
    assign req_tag = s1_addr[WORD_SEL_W+LINE_ADDR_W +: TAG_W];

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1 support

    // Blocks a second request once memory has acked
    always_ff @(posedge clk) begin
        if (rst || s1_done) begin
            request_sent <= 1'b0;
        end else if (mem_ack) begin
            request_sent <= 1'b1;
        end
    end

    // Fill words arrive in order from word 0
    always_ff @(posedge clk) begin
        if (rst || s1_done) begin
            word_cnt <= '0;
        end else if (mem_rvalid) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    assign fill_last  = mem_rvalid & (word_cnt == word_sel_t'(LINE_WORDS - 1));
    assign fill_match = mem_rvalid & (word_cnt == s1_word);

    // Valid tag goes in the cycle after the read ack
    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_pend <= 1'b0;
        end else begin
            alloc_pend <= mem_ack & s1_valid & (s1_kind == REQ_READ);
        end
    end

    assign alloc_en   = alloc_pend;
    assign alloc_line = s1_line;
    assign alloc_way  = repl_way;

    // Rotating one-hot pointer, stable while a request is in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            repl_way <= way_mask_t'(1);
        end else if (new_request) begin
            repl_way <= {repl_way[WAYS-2:0], repl_way[WAYS-1]};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Per-kind handling

    always_comb begin
        unique case (s1_kind)
            REQ_WRITE: begin
                mem_request = s1_valid & ~request_sent;
                db_wen      = s1_valid & first_cycle & hit;
                db_way      = hit_way;
                db_be       = s1_be;
                db_wdata    = s1_wdata;
                data_valid  = 1'b0;
                s1_done     = s1_valid & mem_ack;
            end
            REQ_READ: begin
                // Miss goes to memory in the cycle the tag result is known
                mem_request = s1_valid & ~request_sent & ~(first_cycle & hit);
                db_wen      = s1_valid & mem_rvalid;
                db_way      = repl_way;
                db_be       = '1;
                db_wdata    = mem_rdata;
                data_valid  = s1_valid & (first_cycle ? hit : fill_match);
                s1_done     = s1_valid & (first_cycle ? hit : fill_last);
            end
        endcase
    end

    assign db_waddr = {s1_line, (s1_kind == REQ_READ) ? word_cnt : s1_word};
    assign data_out = first_cycle ? hit_word : mem_rdata;

    // Reads fetch the whole line from its first word
    assign mem_rnw   = (s1_kind == REQ_READ);
    assign mem_addr  = mem_rnw ? {s1_addr[$bits(word_addr_t)-1:WORD_SEL_W], {WORD_SEL_W{1'b0}}}
                               : s1_addr;
    assign mem_wbe   = s1_be;
    assign mem_wdata = s1_wdata;

    assign ready = ~sweeping & ~snoop_busy & (~s1_valid | s1_done) & ~db_wen;
    assign write_outstanding = s1_valid & (s1_kind == REQ_WRITE);

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    request_when_ready: assert property (@(posedge clk) disable iff (rst)
        new_request |-> ready)
        else $error("dcache request while not ready");

    ack_with_request: assert property (@(posedge clk) disable iff (rst)
        mem_ack |-> mem_request)
        else $error("dcache memory ack without a request");

endmodule

/* dcache_data.sv */
// Data bank of the data cache
// One word array per way with byte-enabled writes
// Registered read of all ways, one-hot selection by the hit way

module dcache_data (
    input  logic                                  clk,
    input  logic                                  db_wen,
    input  logic [dcache_geom_pkg::DB_ADDR_W-1:0] db_waddr,
    input  dcache_geom_pkg::way_mask_t            db_way,
    input  dcache_bus_pkg::byte_en_t              db_be,
    input  dcache_bus_pkg::word_t                 db_wdata,
    input  logic                                  db_ren,
    input  logic [dcache_geom_pkg::DB_ADDR_W-1:0] db_raddr,
    input  dcache_geom_pkg::way_mask_t            hit_way,
    output dcache_bus_pkg::word_t                 hit_word
);
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;

    localparam int BYTES = $bits(byte_en_t);

    word_t bank [WAYS][2**DB_ADDR_W];
    word_t rd_word [WAYS];

    ////////////////////////////////////////////////////////////////////////////
    // Write port

    // Byte lanes are written only in the selected way
    always_ff @(posedge clk) begin
        if (db_wen) begin
            for (int w = 0; w < WAYS; w++) begin
                for (int b = 0; b < BYTES; b++) begin
                    if (db_way[w] && db_be[b]) begin
                        bank[w][db_waddr][8*b +: 8] <= db_wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read port

    // All ways are read in the request cycle, the tag result picks one
    always_ff @(posedge clk) begin
        if (db_ren) begin
            for (int w = 0; w < WAYS; w++) begin
                rd_word[w] <= bank[w][db_raddr];
            end
        end
    end

    // OR of the masked ways, zero on a miss
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hit_way[w]) begin
                hit_word = hit_word | rd_word[w];
            end
        end
    end

endmodule

/* dcache_tags.sv */
// Tag bank of the data cache
// Dual-port valid and tag storage for every way
// Post-reset sweep, snoop lookup and invalidation
// Hit detection for the request in stage 1

module dcache_tags (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       lookup_en,
    input  dcache_geom_pkg::line_t     lookup_line,
    input  dcache_geom_pkg::tag_t      req_tag,
    input  logic                       alloc_en,
    input  dcache_geom_pkg::line_t     alloc_line,
    input  dcache_geom_pkg::way_mask_t alloc_way,
    input  logic                       mem_inv,
    input  dcache_bus_pkg::byte_addr_t mem_inv_addr,
    output logic                       hit,
    output dcache_geom_pkg::way_mask_t hit_way,
    output logic                       snoop_busy,
    output logic                       sweeping
);
    import dcache_geom_pkg::*;

    // Entry layout is valid bit on top of the tag
    logic [TAG_W:0] bank [WAYS][2**LINE_ADDR_W];

    logic           a_en;
    way_mask_t      a_wbe;
    line_t          a_addr;
    logic [TAG_W:0] a_wdata;
    logic [TAG_W:0] a_rdata [WAYS];

    logic           b_en;
    line_t          b_addr;
    logic [TAG_W:0] b_rdata [WAYS];

    line_t     snoop_line;
    tag_t      snoop_tag;
    logic      snoop_valid;
    line_t     snoop_line_r;
    tag_t      snoop_tag_r;
    way_mask_t snoop_hit;

    logic  sweep_done;
    line_t sweep_line;

    ////////////////////////////////////////////////////////////////////////////
    // Reset sweep, one line index per cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            {sweep_done, sweep_line} <= '0;
        end else if (!sweep_done) begin
            {sweep_done, sweep_line} <= {1'b0, sweep_line} + 1'b1;
        end
    end

    assign sweeping = ~sweep_done;

    ////////////////////////////////////////////////////////////////////////////
    // Snoop path

    assign snoop_line = mem_inv_addr[2+WORD_SEL_W +: LINE_ADDR_W];
    assign snoop_tag  = mem_inv_addr[2+WORD_SEL_W+LINE_ADDR_W +: TAG_W];

    // Nothing is valid during the sweep, so snoops are dropped then
    always_ff @(posedge clk) begin
        if (rst) begin
            snoop_valid <= 1'b0;
        end else begin
            snoop_valid <= mem_inv & sweep_done;
        end
        snoop_line_r <= snoop_line;
        snoop_tag_r  <= snoop_tag;
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            snoop_hit[w] = b_rdata[w][TAG_W] & (b_rdata[w][TAG_W-1:0] == snoop_tag_r);
        end
    end

    assign snoop_busy = snoop_valid & (|snoop_hit);

    ////////////////////////////////////////////////////////////////////////////
    // Bank ports
    // A serves lookups and allocation, snoop clears win
    // B serves snoop reads and the sweep

    assign a_en    = snoop_busy | alloc_en | lookup_en;
    assign a_wbe   = snoop_busy ? snoop_hit : (alloc_en ? alloc_way : '0);
    assign a_addr  = snoop_busy ? snoop_line_r : (alloc_en ? alloc_line : lookup_line);
    assign a_wdata = {~snoop_busy, req_tag};

    assign b_en   = sweeping | mem_inv;
    assign b_addr = sweeping ? sweep_line : snoop_line;

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (a_en) begin
                if (a_wbe[w]) begin
                    bank[w][a_addr] <= a_wdata;
                end
                a_rdata[w] <= bank[w][a_addr];
            end
            if (b_en) begin
                if (sweeping) begin
                    bank[w][b_addr] <= '0;
                end
                b_rdata[w] <= bank[w][b_addr];
            end
        end
    end

    // Request hit, valid the cycle after the lookup
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_way[w] = a_rdata[w][TAG_W] & (a_rdata[w][TAG_W-1:0] == req_tag);
        end
    end

    assign hit = |hit_way;

    // A line is never allocated twice, so no tag sits in two ways
    single_way_hit: assert property (@(posedge clk) disable iff (rst)
        $past(lookup_en) |-> $onehot0(hit_way))
        else $error("dcache tag lookup hit in more than one way");

endmodule

/* dcache_bus_pkg.sv */
// Load/store port and memory bus types
// Data word, byte enables, byte and word addresses
// Request kinds held in the cache pipeline

package dcache_bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;

    // Byte address from the CPU, word address toward memory
    typedef logic [31:0] byte_addr_t;
    typedef logic [29:0] word_addr_t;

    // Kind of request sitting in stage 1
    typedef enum logic {
        REQ_READ,
        REQ_WRITE
    } req_kind_t;

endpackage

/* dcache_geom_pkg.sv */
// Geometry of the write-through data cache
// Way count, line size and address field widths
// Vector types for tags, line indexes, word selects and way masks

package dcache_geom_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes

    // Two ways of 32 lines, four words per line
    localparam int WAYS        = 2;
    localparam int LINE_WORDS  = 4;
    localparam int LINE_ADDR_W = 5;
    localparam int WORD_SEL_W  = $clog2(LINE_WORDS);

    // A 30-bit word address splits into tag, line index and word select
    localparam int TAG_W     = 30 - LINE_ADDR_W - WORD_SEL_W;
    localparam int DB_ADDR_W = LINE_ADDR_W + WORD_SEL_W;

    ////////////////////////////////////////////////////////////////////////////
    // Address field types

    typedef logic [TAG_W-1:0]       tag_t;
    typedef logic [LINE_ADDR_W-1:0] line_t;
    typedef logic [WORD_SEL_W-1:0]  word_sel_t;

    // One bit per way, one-hot where a single way is meant
    typedef logic [WAYS-1:0] way_mask_t;

endpackage
